// File: files.f
+incdir+verification
hdl/axis_pkg.sv
hdl/axis_frame_fifo.sv
hdl/axis_frame_arbiter.sv
hdl/frame_stat_counters.sv
hdl/axis_merge_top.sv
verification/axis_merge_tb.sv

// File: verification/axis_merge_model.svh
`ifndef AXIS_MERGE_MODEL_SVH
`define AXIS_MERGE_MODEL_SVH

// good frames per port in sending order with beats stored flat
axis_pkg::axis_beat_t exp_beats [axis_pkg::num_ports][$];
int exp_len [axis_pkg::num_ports][$];
axis_pkg::axis_out_beat_t rcvd_beats [$]; // frame being collected from m

int good_sent [axis_pkg::num_ports];
int bad_sent [axis_pkg::num_ports];
int good_rcvd [axis_pkg::num_ports];

function automatic void expect_frame(input int port, input int len);
  exp_len[port].push_back(len);
  good_sent[port]++;
endfunction

function automatic void expect_beat(input int port, input axis_pkg::axis_beat_t beat);
  exp_beats[port].push_back(beat);
endfunction

function automatic bit front_matches(input int port);
  int n;
  int i;
  n = rcvd_beats.size();
  if (exp_len[port].size() == 0 || exp_len[port][0] != n) begin
    return 1'b0;
  end
  for (i = 0; i < n; i++) begin
    if (rcvd_beats[i].data != exp_beats[port][i].data ||
        rcvd_beats[i].dest != exp_beats[port][i].dest ||
        rcvd_beats[i].last != exp_beats[port][i].last) begin
      return 1'b0;
    end
  end
  return 1'b1;
endfunction

function automatic void drop_front(input int port);
  repeat (exp_len[port][0]) begin
    void'(exp_beats[port].pop_front());
  end
  void'(exp_len[port].pop_front());
endfunction

task automatic check_frame(input int port);
  int n;
  n = rcvd_beats.size();
  // frames lost to a full FIFO never come out
  while (exp_len[port].size() > 0 && !front_matches(port)) begin
    drop_front(port);
  end
  assert (exp_len[port].size() > 0) else begin
    $display("[ERROR] m_beat frame from port %0d of %0d beats, first data %h,",
             port, n, rcvd_beats[0].data);
    $display("matches no sent frame");
    stop_with_failure();
  end
  assert (n <= axis_pkg::fifo_depth) else begin
    $display("a frame of %0d beats from port %0d is longer than the FIFO but came out", n, port);
    stop_with_failure();
  end
  drop_front(port);
  good_rcvd[port]++;
  rcvd_beats.delete();
endtask

task automatic take_beat(input axis_pkg::axis_out_beat_t beat);
  rcvd_beats.push_back(beat);
  if (beat.last) begin
    check_frame(int'(beat.src));
  end
endtask

task automatic check_counts(input int port, input axis_pkg::frame_counts_t cnt);
  assert (cnt.bad == bad_sent[port]) else begin
    $display("[ERROR] counts%0d.bad = %h, expected %h", port, cnt.bad, bad_sent[port]);
    stop_with_failure();
  end
  assert (cnt.good == good_rcvd[port]) else begin
    $display("[ERROR] counts%0d.good = %h, expected %h", port, cnt.good, good_rcvd[port]);
    stop_with_failure();
  end
  assert (cnt.good + cnt.overflow == good_sent[port]) else begin
    $display("[ERROR] counts%0d.good + counts%0d.overflow = %h, expected %h",
             port, port, cnt.good + cnt.overflow, good_sent[port]);
    stop_with_failure();
  end
endtask

`endif

// File: verification/axis_merge_tb.sv
`timescale 1ns/10ps

module axis_merge_tb;

  localparam int frames_per_port = 60;
  localparam int max_frame_len = 20;

  logic clk;
  logic rst;
  axis_pkg::axis_beat_t s_beat [axis_pkg::num_ports];
  logic s_valid [axis_pkg::num_ports];
  logic s_ready [axis_pkg::num_ports];
  axis_pkg::axis_out_beat_t m_beat;
  logic m_valid;
  logic m_ready;
  axis_pkg::frame_counts_t counts [axis_pkg::num_ports];

  // every beat of a port and the idle cycles before it
  axis_pkg::axis_beat_t stim_beats [axis_pkg::num_ports][$];
  int stim_gap [axis_pkg::num_ports][$];
  int total_beats;
  bit stim_built;
  bit monitor_on;
  bit held_valid;
  axis_pkg::axis_out_beat_t held_beat;
  bit in_frame;
  logic frame_src;

  `include "axis_merge_model.svh"

  axis_merge_top u_dut (
    .clk      (clk),
    .rst      (rst),
    .s0_beat  (s_beat[0]),
    .s1_beat  (s_beat[1]),
    .s0_valid (s_valid[0]),
    .s1_valid (s_valid[1]),
    .s0_ready (s_ready[0]),
    .s1_ready (s_ready[1]),
    .m_beat   (m_beat),
    .m_valid  (m_valid),
    .m_ready  (m_ready),
    .counts0  (counts[0]),
    .counts1  (counts[1])
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic stop_with_failure();
    $display("** FAIL **");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic build_stimulus();
    int len;
    bit bad;
    logic [31:0] r;
    axis_pkg::axis_beat_t beat;
    for (int p = 0; p < axis_pkg::num_ports; p++) begin
      for (int f = 0; f < frames_per_port; f++) begin
        len = $urandom_range(1, max_frame_len);
        bad = $urandom_range(0, 5) == 0; // about one in six
        if (bad) begin
          bad_sent[p]++;
        end else begin
          expect_frame(p, len);
        end
        for (int i = 0; i < len; i++) begin
          r = $urandom;
          beat.data = r[7:0];
          beat.dest = r[8 +: axis_pkg::dest_width];
          beat.last = i == len - 1;
          beat.user = beat.last && bad;
          stim_beats[p].push_back(beat);
          if (i == 0) begin
            stim_gap[p].push_back($urandom_range(0, 6));
          end else begin
            stim_gap[p].push_back(r[31:30] == 2'b00 ? 1 : 0); // hole mid frame
          end
          if (!bad) begin
            expect_beat(p, beat);
          end
          total_beats++;
        end
      end
    end
    stim_built = 1'b1;
  endtask

  task automatic drive_port(input int port);
    axis_pkg::axis_beat_t beat;
    int gap;
    while (stim_beats[port].size() > 0) begin
      beat = stim_beats[port].pop_front();
      gap = stim_gap[port].pop_front();
      s_valid[port] = 1'b0;
      repeat (gap) begin
        @(posedge clk);
        #1;
      end
      s_beat[port] = beat;
      s_valid[port] = 1'b1;
      do begin
        @(posedge clk);
      end while (!s_ready[port]);
      #1;
    end
    s_valid[port] = 1'b0;
  endtask

  task automatic check_reset_state();
    assert (m_valid == 1'b0) else begin
      $display("[ERROR] m_valid = %h after reset, expected 0", m_valid);
      stop_with_failure();
    end
    for (int p = 0; p < axis_pkg::num_ports; p++) begin
      assert (counts[p] == '0) else begin
        $display("[ERROR] counts%0d = %h after reset, expected 0", p, counts[p]);
        stop_with_failure();
      end
      assert (s_ready[p] == 1'b1) else begin
        $display("[ERROR] s%0d_ready = %h after reset, expected 1", p, s_ready[p]);
        stop_with_failure();
      end
    end
  endtask

  // every frame finished and every good one seen on m
  task automatic wait_for_drain();
    bit done;
    done = 1'b0;
    while (!done) begin
      @(posedge clk);
      #2;
      done = !m_valid;
      for (int p = 0; p < axis_pkg::num_ports; p++) begin
        if (counts[p].good + counts[p].bad + counts[p].overflow != frames_per_port ||
            counts[p].good != good_rcvd[p]) begin
          done = 1'b0;
        end
      end
    end
  endtask

  initial begin
    rst = 1'b1;
    m_ready = 1'b0;
    for (int p = 0; p < axis_pkg::num_ports; p++) begin
      s_beat[p] = '0;
      s_valid[p] = 1'b0;
    end
    total_beats = 0;
    stim_built = 1'b0;
    monitor_on = 1'b0;
    held_valid = 1'b0;
    in_frame = 1'b0;
    frame_src = 1'b0;
    void'($urandom(15157)); // seeds the generator
    build_stimulus();
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;
    @(posedge clk);
    #1;
    check_reset_state();
    monitor_on = 1'b1;
    fork
      drive_port(0);
      drive_port(1);
    join
    wait_for_drain();
    repeat (2 * axis_pkg::fifo_depth) @(posedge clk); // quiet tail
    #2;
    for (int p = 0; p < axis_pkg::num_ports; p++) begin
      check_counts(p, counts[p]);
    end
    $display("** PASS **");
    $finish;
  end

  initial begin : sink
    wait (monitor_on);
    forever begin
      @(posedge clk);
      #1;
      m_ready = $urandom_range(0, 9) >= 3; // low about 30%
    end
  end

  always @(posedge clk) begin
    if (monitor_on) begin
      assert (s_ready[0] && s_ready[1]) else begin
        $display("[ERROR] s0_ready = %h, s1_ready = %h, expected 1", s_ready[0], s_ready[1]);
        stop_with_failure();
      end
      if (held_valid) begin
        assert (m_valid && m_beat == held_beat) else begin
          $display("[ERROR] m_beat = %h, m_valid = %h while stalled, expected %h, 1",
                   m_beat, m_valid, held_beat);
          stop_with_failure();
        end
      end
      if (m_valid && m_ready) begin
        if (in_frame) begin
          assert (m_beat.src == frame_src) else begin
            $display("[ERROR] m_beat.src = %h inside a frame, expected %h", m_beat.src, frame_src);
            stop_with_failure();
          end
        end
        assert (m_beat.user == 1'b0) else begin
          $display("[ERROR] m_beat.user = %h, expected 0", m_beat.user);
          stop_with_failure();
        end
        in_frame = !m_beat.last;
        frame_src = m_beat.src;
        take_beat(m_beat);
      end
      held_valid = m_valid && !m_ready;
      held_beat = m_beat;
    end
  end

  initial begin : watchdog
    wait (stim_built);
    repeat (2 * total_beats * 40) @(posedge clk);
    $display("timeout, the run did not finish within %0d cycles", 2 * total_beats * 40);
    stop_with_failure();
  end

endmodule

// File: hdl/axis_merge_top.sv
`timescale 1ns/10ps

module axis_merge_top (
  input  logic                      clk,
  input  logic                      rst,
  input  axis_pkg::axis_beat_t      s0_beat,
  input  axis_pkg::axis_beat_t      s1_beat,
  input  logic                      s0_valid,
  input  logic                      s1_valid,
  output logic                      s0_ready,
  output logic                      s1_ready,
  output axis_pkg::axis_out_beat_t  m_beat,
  output logic                      m_valid,
  input  logic                      m_ready,
  output axis_pkg::frame_counts_t   counts0,
  output axis_pkg::frame_counts_t   counts1
);

  // fifo to arbiter
  axis_pkg::axis_beat_t f0_beat;
  axis_pkg::axis_beat_t f1_beat;
  logic f0_valid;
  logic f1_valid;
  logic f0_ready;
  logic f1_ready;

  axis_pkg::frame_status_t status0;
  axis_pkg::frame_status_t status1;

  axis_frame_fifo fifo0 (
    .clk     (clk),
    .rst     (rst),
    .s_beat  (s0_beat),
    .s_valid (s0_valid),
    .s_ready (s0_ready),
    .m_beat  (f0_beat),
    .m_valid (f0_valid),
    .m_ready (f0_ready),
    .status  (status0)
  );

  axis_frame_fifo fifo1 (
    .clk     (clk),
    .rst     (rst),
    .s_beat  (s1_beat),
    .s_valid (s1_valid),
    .s_ready (s1_ready),
    .m_beat  (f1_beat),
    .m_valid (f1_valid),
    .m_ready (f1_ready),
    .status  (status1)
  );

  axis_frame_arbiter arb (
    .clk       (clk),
    .rst       (rst),
    .in_beat0  (f0_beat),
    .in_beat1  (f1_beat),
    .in_valid0 (f0_valid),
    .in_valid1 (f1_valid),
    .in_ready0 (f0_ready),
    .in_ready1 (f1_ready),
    .m_beat    (m_beat),
    .m_valid   (m_valid),
    .m_ready   (m_ready)
  );

  frame_stat_counters stats (
    .clk     (clk),
    .rst     (rst),
    .status0 (status0),
    .status1 (status1),
    .counts0 (counts0),
    .counts1 (counts1)
  );

endmodule

// File: hdl/frame_stat_counters.sv
`timescale 1ns/10ps

module frame_stat_counters (
  input  logic                     clk,
  input  logic                     rst,
  input  axis_pkg::frame_status_t  status0,
  input  axis_pkg::frame_status_t  status1,
  output axis_pkg::frame_counts_t  counts0,
  output axis_pkg::frame_counts_t  counts1
);

  axis_pkg::frame_status_t status_arr [axis_pkg::num_ports];
  axis_pkg::frame_counts_t count_arr [axis_pkg::num_ports];

  assign status_arr[0] = status0;
  assign status_arr[1] = status1;
  assign counts0 = count_arr[0];
  assign counts1 = count_arr[1];

  // add one per pulse, hold at all ones
  function automatic logic [axis_pkg::count_width-1:0] sat_inc(
    input logic [axis_pkg::count_width-1:0] value,
    input logic                             pulse
  );
    if (pulse && (value != '1)) begin
      return value + 1'b1;
    end
    return value;
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < axis_pkg::num_ports; i++) begin
        count_arr[i] <= '0;
      end
    end else begin
      for (int i = 0; i < axis_pkg::num_ports; i++) begin
        count_arr[i].good <= sat_inc(count_arr[i].good, status_arr[i].good);
        count_arr[i].bad <= sat_inc(count_arr[i].bad, status_arr[i].bad);
        count_arr[i].overflow <= sat_inc(count_arr[i].overflow, status_arr[i].overflow);
      end
    end
  end

endmodule

// File: hdl/axis_frame_arbiter.sv
`timescale 1ns/10ps

module axis_frame_arbiter (
  input  logic                      clk,
  input  logic                      rst,
  input  axis_pkg::axis_beat_t      in_beat0,
  input  axis_pkg::axis_beat_t      in_beat1,
  input  logic                      in_valid0,
  input  logic                      in_valid1,
  output logic                      in_ready0,
  output logic                      in_ready1,
  output axis_pkg::axis_out_beat_t  m_beat,
  output logic                      m_valid,
  input  logic                      m_ready
);

  logic grant;  // port in a frame, or last one served
  logic locked; // mid-frame, grant may not move
  logic sel;
  logic sel_valid;
  logic take;
  logic xfer;
  axis_pkg::axis_beat_t sel_beat;

  // round robin: the other port first when idle
  always_comb begin
    if (locked) begin
      sel = grant;
    end else if (grant ? in_valid0 : in_valid1) begin
      sel = !grant;
    end else begin
      sel = grant;
    end
  end

  assign sel_beat = sel ? in_beat1 : in_beat0;
  assign sel_valid = sel ? in_valid1 : in_valid0;

  // single output stage, refill when empty or draining
  assign take = m_ready || !m_valid;
  assign xfer = take && sel_valid;

  assign in_ready0 = take && !sel;
  assign in_ready1 = take && sel;

  always_ff @(posedge clk) begin
    if (rst) begin
      grant <= 1'b1; // port 0 wins first
      locked <= 1'b0;
      m_valid <= 1'b0;
    end else begin
      if (xfer) begin
        grant <= sel;
        locked <= !sel_beat.last; // release after last beat
        m_valid <= 1'b1;
      end else if (m_ready) begin
        m_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (xfer) begin
      m_beat.data <= sel_beat.data;
      m_beat.last <= sel_beat.last;
      m_beat.dest <= sel_beat.dest;
      m_beat.user <= sel_beat.user;
      m_beat.src <= sel;
    end
  end

endmodule

// File: hdl/axis_frame_fifo.sv
`timescale 1ns/10ps

module axis_frame_fifo (
  input  logic                     clk,
  input  logic                     rst,
  input  axis_pkg::axis_beat_t     s_beat,
  input  logic                     s_valid,
  output logic                     s_ready,
  output axis_pkg::axis_beat_t     m_beat,
  output logic                     m_valid,
  input  logic                     m_ready,
  output axis_pkg::frame_status_t  status
);

  // pointers carry one extra wrap bit
  logic [axis_pkg::fifo_addr_width:0] wr_ptr;      // committed
  logic [axis_pkg::fifo_addr_width:0] wr_ptr_next;
  logic [axis_pkg::fifo_addr_width:0] wr_ptr_cur;  // speculative
  logic [axis_pkg::fifo_addr_width:0] wr_ptr_cur_next;
  logic [axis_pkg::fifo_addr_width:0] rd_ptr;
  logic [axis_pkg::fifo_addr_width:0] used_cur;

  axis_pkg::axis_beat_t mem [axis_pkg::fifo_depth];
  axis_pkg::axis_beat_t rd_data; // memory read register
  logic rd_valid;

  logic full_cur;
  logic empty;
  logic write;
  logic read;
  logic store_out;
  logic drop_frame;
  logic drop_frame_next;
  axis_pkg::frame_status_t status_next;

  assign used_cur = wr_ptr_cur - rd_ptr;
  assign full_cur = used_cur == (axis_pkg::fifo_addr_width + 1)'(axis_pkg::fifo_depth);
  assign empty = wr_ptr == rd_ptr; // only committed frames are visible

  // write side: commit, rewind or drop
  always_comb begin
    write = 1'b0;
    wr_ptr_next = wr_ptr;
    wr_ptr_cur_next = wr_ptr_cur;
    drop_frame_next = drop_frame;
    status_next = '0;
    if (s_valid && s_ready) begin
      if (full_cur || drop_frame) begin
        drop_frame_next = 1'b1; // swallow rest of frame
        if (s_beat.last) begin
          wr_ptr_cur_next = wr_ptr;
          drop_frame_next = 1'b0;
          status_next.bad = s_beat.user;
          status_next.overflow = !s_beat.user;
        end
      end else begin
        write = 1'b1;
        wr_ptr_cur_next = wr_ptr_cur + 1'b1;
        if (s_beat.last) begin
          if (s_beat.user) begin
            wr_ptr_cur_next = wr_ptr; // discard bad frame
            status_next.bad = 1'b1;
          end else begin
            wr_ptr_next = wr_ptr_cur + 1'b1;
            status_next.good = 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      wr_ptr_cur <= '0;
      drop_frame <= 1'b0;
      status <= '0;
      s_ready <= 1'b0;
    end else begin
      wr_ptr <= wr_ptr_next;
      wr_ptr_cur <= wr_ptr_cur_next;
      drop_frame <= drop_frame_next;
      status <= status_next;
      s_ready <= 1'b1; // never back-pressures
    end
  end

  always_ff @(posedge clk) begin
    if (write) begin
      mem[wr_ptr_cur[axis_pkg::fifo_addr_width-1:0]] <= s_beat;
    end
  end

  // read side: memory read register, then output register
  assign store_out = m_ready || !m_valid;
  assign read = !empty && (store_out || !rd_valid);

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr <= '0;
      rd_valid <= 1'b0;
      m_valid <= 1'b0;
    end else begin
      if (read) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (store_out || !rd_valid) begin
        rd_valid <= !empty;
      end
      if (store_out) begin
        m_valid <= rd_valid;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (read) begin
      rd_data <= mem[rd_ptr[axis_pkg::fifo_addr_width-1:0]];
    end
    if (store_out && rd_valid) begin
      m_beat <= rd_data;
    end
  end

endmodule

// File: hdl/axis_pkg.sv
package axis_pkg;

  localparam int fifo_addr_width = 4;
  localparam int fifo_depth = 2 ** fifo_addr_width;
  localparam int dest_width = 4;
  localparam int num_ports = 2;
  localparam int count_width = 16;

  typedef struct packed {
    logic [7:0] data;
    logic last;
    logic [dest_width-1:0] dest;
    logic user; // bad frame flag, valid on last beat
  } axis_beat_t;

  typedef struct packed {
    logic [7:0] data;
    logic last;
    logic [dest_width-1:0] dest;
    logic user;
    logic src; // input port the beat came from
  } axis_out_beat_t;

  // one-cycle pulses, one per finished frame
  typedef struct packed {
    logic good;
    logic bad;
    logic overflow;
  } frame_status_t;

  typedef struct packed {
    logic [count_width-1:0] good;
    logic [count_width-1:0] bad;
    logic [count_width-1:0] overflow;
  } frame_counts_t;

endpackage
